//--- verilog/rtos_defines.svh
// sizes and ids are fixed at build time; object ids start at 1 and id 0 is never valid
`ifndef RTOS_DEFINES_SVH
`define RTOS_DEFINES_SVH

// --------------------
// bus and object sizes
`define RTOS_DAT_W          32
`define RTOS_ADR_W          16
`define RTOS_SEL_W          4
`define RTOS_TMAX_TSKID     7
`define RTOS_TSKID_W        3
`define RTOS_TMAX_SEMID     3
`define RTOS_SEMCNT_W       4
`define RTOS_TMAX_FLGID     2
`define RTOS_FLGPTN_W       16
`define RTOS_CORE_ID        32'h834f5452

// --------------------
// opcodes, upper address byte
`define RTOS_OPC_SYS_CFG     8'h00
`define RTOS_OPC_CPU_CTL     8'h01
`define RTOS_OPC_WUP_TSK     8'h10
`define RTOS_OPC_SLP_TSK     8'h11
`define RTOS_OPC_SIG_SEM     8'h21
`define RTOS_OPC_POL_SEM     8'h23
`define RTOS_OPC_SET_FLG     8'h31
`define RTOS_OPC_CLR_FLG     8'h32
`define RTOS_OPC_REF_TSKSTAT 8'h90
`define RTOS_OPC_REF_SEMCNT  8'ha0
`define RTOS_OPC_REF_FLGPTN  8'hb0

// processor control ids
`define RTOS_CTL_TOP_TSKID   8'h00
`define RTOS_CTL_RUN_TSKID   8'h04
`define RTOS_CTL_COPY_TSKID  8'h08
`define RTOS_CTL_IRQ_EN      8'h10
`define RTOS_CTL_IRQ_STS     8'h11

// configuration ids
`define RTOS_CFG_CORE_ID     8'h00
`define RTOS_CFG_TMAX_TSKID  8'h20
`define RTOS_CFG_TMAX_SEMID  8'h21
`define RTOS_CFG_TMAX_FLGID  8'h22

`endif

//--- verilog/rtos_pkg.sv
// opcode values come from the defines header; reads are split by object class
`include "rtos_defines.svh"

package rtos_pkg;

    // --------------------
    // bus opcodes
    typedef enum logic [7:0] {
        OPC_SYS_CFG     = `RTOS_OPC_SYS_CFG,
        OPC_CPU_CTL     = `RTOS_OPC_CPU_CTL,
        OPC_WUP_TSK     = `RTOS_OPC_WUP_TSK,
        OPC_SLP_TSK     = `RTOS_OPC_SLP_TSK,
        OPC_SIG_SEM     = `RTOS_OPC_SIG_SEM,
        OPC_POL_SEM     = `RTOS_OPC_POL_SEM,
        OPC_SET_FLG     = `RTOS_OPC_SET_FLG,
        OPC_CLR_FLG     = `RTOS_OPC_CLR_FLG,
        OPC_REF_TSKSTAT = `RTOS_OPC_REF_TSKSTAT,
        OPC_REF_SEMCNT  = `RTOS_OPC_REF_SEMCNT,
        OPC_REF_FLGPTN  = `RTOS_OPC_REF_FLGPTN
    } rtos_opcode_e;

    // --------------------
    // decoded commands, one per acknowledged access
    // the read kinds let the result mux work from command and id alone
    typedef enum logic [3:0] {
        CMD_NONE       = 4'd0,
        CMD_WUP_TSK    = 4'd1,
        CMD_SLP_TSK    = 4'd2,
        CMD_SET_RUN    = 4'd3,
        CMD_SET_IRQ_EN = 4'd4,
        CMD_SIG_SEM    = 4'd5,
        CMD_POL_SEM    = 4'd6,
        CMD_SET_FLG    = 4'd7,
        CMD_CLR_FLG    = 4'd8,
        CMD_COPY_TOP   = 4'd9,
        CMD_RD_CFG     = 4'd10,
        CMD_RD_CTL     = 4'd11,
        CMD_RD_TSK     = 4'd12,
        CMD_RD_SEM     = 4'd13,
        CMD_RD_FLG     = 4'd14
    } rtos_cmd_e;

    // task state as returned by a state reference
    typedef enum logic [2:0] {
        TTS_RDY = 3'd1,
        TTS_SLP = 3'd4
    } rtos_tskstat_e;

endpackage

//--- verilog/rtos_bus_decode.sv
// ack equals stb, no wait states; writes need every byte select, reads ignore the selects
`timescale 1ns/1ps

`include "rtos_defines.svh"

module rtos_bus_decode (
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [`RTOS_ADR_W-1:0] adr_i,
    input  logic [`RTOS_SEL_W-1:0] sel_i,
    input  logic [`RTOS_DAT_W-1:0] dat_i,
    output logic                   ack_o,
    output rtos_pkg::rtos_cmd_e    cmd_o,
    output logic [7:0]             id_o,
    output logic [`RTOS_DAT_W-1:0] wdat_o
);

    logic [7:0] opcode;
    logic [7:0] id;
    logic       wr_ok;
    logic       rd_ok;
    logic       tsk_ok;
    logic       sem_ok;
    logic       flg_ok;

    // object ids run from 1 up to the highest id of their kind
    function automatic logic id_in_range(input logic [7:0] obj_id, input logic [7:0] tmax);
        return (obj_id != 8'd0) && (obj_id <= tmax);
    endfunction

    assign opcode = adr_i[15:8];
    assign id     = adr_i[7:0];

    assign ack_o  = stb_i;
    assign wr_ok  = stb_i && we_i && (&sel_i);
    assign rd_ok  = stb_i && !we_i;
    assign id_o   = id;
    assign wdat_o = dat_i;

    assign tsk_ok = id_in_range(id, 8'(`RTOS_TMAX_TSKID));
    assign sem_ok = id_in_range(id, 8'(`RTOS_TMAX_SEMID));
    assign flg_ok = id_in_range(id, 8'(`RTOS_TMAX_FLGID));

    always_comb begin
        cmd_o = rtos_pkg::CMD_NONE;
        if (wr_ok) begin
            case (opcode)
                rtos_pkg::OPC_CPU_CTL: begin
                    if (id == `RTOS_CTL_RUN_TSKID) begin
                        cmd_o = rtos_pkg::CMD_SET_RUN;
                    end else if (id == `RTOS_CTL_IRQ_EN) begin
                        cmd_o = rtos_pkg::CMD_SET_IRQ_EN;
                    end
                end
                rtos_pkg::OPC_WUP_TSK: if (tsk_ok) cmd_o = rtos_pkg::CMD_WUP_TSK;
                rtos_pkg::OPC_SLP_TSK: if (tsk_ok) cmd_o = rtos_pkg::CMD_SLP_TSK;
                rtos_pkg::OPC_SIG_SEM: if (sem_ok) cmd_o = rtos_pkg::CMD_SIG_SEM;
                rtos_pkg::OPC_SET_FLG: if (flg_ok) cmd_o = rtos_pkg::CMD_SET_FLG;
                rtos_pkg::OPC_CLR_FLG: if (flg_ok) cmd_o = rtos_pkg::CMD_CLR_FLG;
                default: ;
            endcase
        end else if (rd_ok) begin
            // poll and copy change state but only ever come in on a read
            case (opcode)
                rtos_pkg::OPC_SYS_CFG: cmd_o = rtos_pkg::CMD_RD_CFG;
                rtos_pkg::OPC_CPU_CTL: begin
                    if (id == `RTOS_CTL_COPY_TSKID) begin
                        cmd_o = rtos_pkg::CMD_COPY_TOP;
                    end else begin
                        cmd_o = rtos_pkg::CMD_RD_CTL;
                    end
                end
                rtos_pkg::OPC_POL_SEM:     if (sem_ok) cmd_o = rtos_pkg::CMD_POL_SEM;
                rtos_pkg::OPC_REF_TSKSTAT: if (tsk_ok) cmd_o = rtos_pkg::CMD_RD_TSK;
                rtos_pkg::OPC_REF_SEMCNT:  if (sem_ok) cmd_o = rtos_pkg::CMD_RD_SEM;
                rtos_pkg::OPC_REF_FLGPTN:  if (flg_ok) cmd_o = rtos_pkg::CMD_RD_FLG;
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/rtos_task_sched.sv
// task ids arrive range-checked; top id reads 0 when no task is ready, irq needs a 2-cycle mismatch
`timescale 1ns/1ps

`include "rtos_defines.svh"

module rtos_task_sched (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  rtos_pkg::rtos_cmd_e                 cmd_i,
    input  logic [7:0]                          id_i,
    input  logic [`RTOS_DAT_W-1:0]              wdat_i,
    output logic [`RTOS_TSKID_W-1:0]            top_tskid_o,
    output logic [`RTOS_TSKID_W-1:0]            run_tskid_o,
    output logic [`RTOS_TMAX_TSKID:1][2:0]      tskstat_o,
    output logic                                irq_en_o,
    output logic                                irq_o
);

    localparam int TMAX = `RTOS_TMAX_TSKID;
    localparam int TW   = `RTOS_TSKID_W;

    logic [TMAX:1]  rdy_q;
    logic [TW-1:0]  top_tskid;
    logic [TW-1:0]  run_q;
    logic           irq_en_q;
    logic           mis;
    logic           mis_q;
    logic           irq_q;

    // --------------------
    // ready or sleeping per task
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdy_q <= '1;
        end else begin
            for (int i = 1; i <= TMAX; i++) begin
                if (id_i == 8'(i)) begin
                    if (cmd_i == rtos_pkg::CMD_WUP_TSK) begin
                        rdy_q[i] <= 1'b1;
                    end else if (cmd_i == rtos_pkg::CMD_SLP_TSK) begin
                        rdy_q[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // lowest ready id has priority, search from the top down
    always_comb begin
        top_tskid = '0;
        for (int i = TMAX; i >= 1; i--) begin
            if (rdy_q[i]) begin
                top_tskid = TW'(i);
            end
        end
    end

    // --------------------
    // run task, irq enable and the mismatch pipe
    assign mis = (top_tskid != run_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q    <= '0;
            irq_en_q <= 1'b0;
            mis_q    <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            case (cmd_i)
                rtos_pkg::CMD_SET_RUN:    run_q    <= wdat_i[TW-1:0];
                rtos_pkg::CMD_COPY_TOP:   run_q    <= top_tskid;
                rtos_pkg::CMD_SET_IRQ_EN: irq_en_q <= wdat_i[0];
                default: ;
            endcase
            mis_q <= mis;
            irq_q <= mis && mis_q;
        end
    end

    for (genvar g = 1; g <= TMAX; g++) begin : g_stat
        assign tskstat_o[g] = rdy_q[g] ? rtos_pkg::TTS_RDY : rtos_pkg::TTS_SLP;
    end

    assign top_tskid_o = top_tskid;
    assign run_tskid_o = run_q;
    assign irq_en_o    = irq_en_q;
    assign irq_o       = irq_q && irq_en_q;

endmodule

//--- verilog/rtos_sync_obj.sv
// semaphore and flag ids arrive range-checked; counts saturate at 15, no wait queues
`timescale 1ns/1ps

`include "rtos_defines.svh"

module rtos_sync_obj (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    input  rtos_pkg::rtos_cmd_e                         cmd_i,
    input  logic [7:0]                                  id_i,
    input  logic [`RTOS_DAT_W-1:0]                      wdat_i,
    output logic [`RTOS_TMAX_SEMID:1][`RTOS_SEMCNT_W-1:0] semcnt_o,
    output logic [`RTOS_TMAX_FLGID:1][`RTOS_FLGPTN_W-1:0] flgptn_o,
    output logic                                        pol_ok_o
);

    localparam int SMAX = `RTOS_TMAX_SEMID;
    localparam int FMAX = `RTOS_TMAX_FLGID;
    localparam int FW   = `RTOS_FLGPTN_W;

    logic [SMAX:1][`RTOS_SEMCNT_W-1:0] sem_q;
    logic [FMAX:1][FW-1:0]             flg_q;

    // --------------------
    // semaphores
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sem_q <= '0;
        end else begin
            for (int i = 1; i <= SMAX; i++) begin
                if (id_i == 8'(i)) begin
                    if (cmd_i == rtos_pkg::CMD_SIG_SEM && sem_q[i] != '1) begin
                        sem_q[i] <= sem_q[i] + 1'b1;
                    end else if (cmd_i == rtos_pkg::CMD_POL_SEM && sem_q[i] != '0) begin
                        sem_q[i] <= sem_q[i] - 1'b1;
                    end
                end
            end
        end
    end

    // poll succeeds on a nonzero count
    always_comb begin
        pol_ok_o = 1'b0;
        for (int i = 1; i <= SMAX; i++) begin
            if (id_i == 8'(i)) begin
                pol_ok_o = (sem_q[i] != '0);
            end
        end
    end

    // --------------------
    // event flags
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flg_q <= '0;
        end else begin
            for (int i = 1; i <= FMAX; i++) begin
                if (id_i == 8'(i)) begin
                    if (cmd_i == rtos_pkg::CMD_SET_FLG) begin
                        flg_q[i] <= flg_q[i] | wdat_i[FW-1:0];
                    end else if (cmd_i == rtos_pkg::CMD_CLR_FLG) begin
                        // clear keeps the bits set in the mask
                        flg_q[i] <= flg_q[i] & wdat_i[FW-1:0];
                    end
                end
            end
        end
    end

    assign semcnt_o = sem_q;
    assign flgptn_o = flg_q;

endmodule

//--- verilog/rtos_read_mux.sv
// purely combinational read data; unmapped reads and non-read commands return 0
`timescale 1ns/1ps

`include "rtos_defines.svh"

module rtos_read_mux (
    input  rtos_pkg::rtos_cmd_e                           cmd_i,
    input  logic [7:0]                                    id_i,
    input  logic [`RTOS_TSKID_W-1:0]                      top_tskid_i,
    input  logic [`RTOS_TSKID_W-1:0]                      run_tskid_i,
    input  logic [`RTOS_TMAX_TSKID:1][2:0]                tskstat_i,
    input  logic                                          irq_en_i,
    input  logic                                          irq_i,
    input  logic [`RTOS_TMAX_SEMID:1][`RTOS_SEMCNT_W-1:0] semcnt_i,
    input  logic [`RTOS_TMAX_FLGID:1][`RTOS_FLGPTN_W-1:0] flgptn_i,
    input  logic                                          pol_ok_i,
    output logic [`RTOS_DAT_W-1:0]                        rdat_o
);

    localparam int DW = `RTOS_DAT_W;

    always_comb begin
        rdat_o = '0;
        case (cmd_i)
            rtos_pkg::CMD_RD_CFG: begin
                case (id_i)
                    `RTOS_CFG_CORE_ID:    rdat_o = `RTOS_CORE_ID;
                    `RTOS_CFG_TMAX_TSKID: rdat_o = DW'(`RTOS_TMAX_TSKID);
                    `RTOS_CFG_TMAX_SEMID: rdat_o = DW'(`RTOS_TMAX_SEMID);
                    `RTOS_CFG_TMAX_FLGID: rdat_o = DW'(`RTOS_TMAX_FLGID);
                    default: ;
                endcase
            end
            rtos_pkg::CMD_RD_CTL: begin
                case (id_i)
                    `RTOS_CTL_TOP_TSKID: rdat_o = DW'(top_tskid_i);
                    `RTOS_CTL_RUN_TSKID: rdat_o = DW'(run_tskid_i);
                    `RTOS_CTL_IRQ_EN:    rdat_o = DW'(irq_en_i);
                    `RTOS_CTL_IRQ_STS:   rdat_o = DW'(irq_i);
                    default: ;
                endcase
            end
            // copy returns the top task it is about to load
            rtos_pkg::CMD_COPY_TOP: rdat_o = DW'(top_tskid_i);
            rtos_pkg::CMD_POL_SEM:  rdat_o = DW'(pol_ok_i);
            rtos_pkg::CMD_RD_TSK: begin
                for (int i = 1; i <= `RTOS_TMAX_TSKID; i++) begin
                    if (id_i == 8'(i)) rdat_o = DW'(tskstat_i[i]);
                end
            end
            rtos_pkg::CMD_RD_SEM: begin
                for (int i = 1; i <= `RTOS_TMAX_SEMID; i++) begin
                    if (id_i == 8'(i)) rdat_o = DW'(semcnt_i[i]);
                end
            end
            rtos_pkg::CMD_RD_FLG: begin
                for (int i = 1; i <= `RTOS_TMAX_FLGID; i++) begin
                    if (id_i == 8'(i)) rdat_o = DW'(flgptn_i[i]);
                end
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/rtos_top.sv
// single-cycle slave with ack = stb; irq_o is level and needs the enable bit set
`timescale 1ns/1ps

`include "rtos_defines.svh"

module rtos_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  logic [`RTOS_ADR_W-1:0] adr_i,
    input  logic [`RTOS_SEL_W-1:0] sel_i,
    input  logic [`RTOS_DAT_W-1:0] dat_i,
    output logic                   ack_o,
    output logic [`RTOS_DAT_W-1:0] dat_o,
    output logic                   irq_o
);

    rtos_pkg::rtos_cmd_e                           cmd;
    logic [7:0]                                    id;
    logic [`RTOS_DAT_W-1:0]                        wdat;
    logic [`RTOS_TSKID_W-1:0]                      top_tskid;
    logic [`RTOS_TSKID_W-1:0]                      run_tskid;
    logic [`RTOS_TMAX_TSKID:1][2:0]                tskstat;
    logic                                          irq_en;
    logic [`RTOS_TMAX_SEMID:1][`RTOS_SEMCNT_W-1:0] semcnt;
    logic [`RTOS_TMAX_FLGID:1][`RTOS_FLGPTN_W-1:0] flgptn;
    logic                                          pol_ok;

    // --------------------
    // decode
    rtos_bus_decode u_dec (
        .stb_i  (stb_i),
        .we_i   (we_i),
        .adr_i  (adr_i),
        .sel_i  (sel_i),
        .dat_i  (dat_i),
        .ack_o  (ack_o),
        .cmd_o  (cmd),
        .id_o   (id),
        .wdat_o (wdat)
    );

    // --------------------
    // execute
    rtos_task_sched u_sched (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_i       (cmd),
        .id_i        (id),
        .wdat_i      (wdat),
        .top_tskid_o (top_tskid),
        .run_tskid_o (run_tskid),
        .tskstat_o   (tskstat),
        .irq_en_o    (irq_en),
        .irq_o       (irq_o)
    );

    rtos_sync_obj u_sync (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .cmd_i    (cmd),
        .id_i     (id),
        .wdat_i   (wdat),
        .semcnt_o (semcnt),
        .flgptn_o (flgptn),
        .pol_ok_o (pol_ok)
    );

    // read data
    rtos_read_mux u_rd (
        .cmd_i       (cmd),
        .id_i        (id),
        .top_tskid_i (top_tskid),
        .run_tskid_i (run_tskid),
        .tskstat_i   (tskstat),
        .irq_en_i    (irq_en),
        .irq_i       (irq_o),
        .semcnt_i    (semcnt),
        .flgptn_i    (flgptn),
        .pol_ok_i    (pol_ok),
        .rdat_o      (dat_o)
    );

endmodule

//--- verification/rtos_chk.sv
// bound into rtos_top; the irq check expects reset to be released between rising edges
`timescale 1ns/1ps

`include "rtos_defines.svh"

module rtos_chk (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stb_i,
    input  logic                     ack_i,
    input  logic                     irq_i,
    input  logic                     irq_en_i,
    input  logic [`RTOS_TSKID_W-1:0] top_tskid_i,
    input  logic [`RTOS_TSKID_W-1:0] run_tskid_i
);

    logic mis;

    assign mis = (top_tskid_i != run_tskid_i);

    // --------------------
    // bus handshake
    a_ack_is_stb: assert property (@(posedge clk) ack_i == stb_i)
        else $error("ack_o differs from stb_i");

    // --------------------
    // interrupt, two sampled edges of mismatch out of reset
    a_irq_after_two: assert property (@(posedge clk) disable iff (!rst_n_i)
        irq_i == (irq_en_i && $past(mis) && $past(mis, 2)
                  && $past(rst_n_i) && $past(rst_n_i, 2)))
        else $error("irq_o does not follow the two-edge task mismatch");

endmodule

bind rtos_top rtos_chk u_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .stb_i       (stb_i),
    .ack_i       (ack_o),
    .irq_i       (irq_o),
    .irq_en_i    (irq_en),
    .top_tskid_i (top_tskid),
    .run_tskid_i (run_tskid)
);

//--- verification/tb_rtos.sv
// one access per clock as ack follows stb; stimulus comes from a fixed seed, no files read
`timescale 1ns/1ps

`include "rtos_defines.svh"

module tb_rtos;

    localparam int CLK_PERIOD = 4;
    localparam int N_DIRECT   = 60;
    localparam int N_RANDOM   = 800;
    localparam int TIMEOUT_NS = (N_DIRECT + 2 * N_RANDOM + 10) * CLK_PERIOD + 100;

    localparam logic [7:0] OPC_TABLE [16] = '{
        `RTOS_OPC_SYS_CFG, `RTOS_OPC_CPU_CTL, `RTOS_OPC_WUP_TSK, `RTOS_OPC_SLP_TSK,
        `RTOS_OPC_SIG_SEM, `RTOS_OPC_POL_SEM, `RTOS_OPC_SET_FLG, `RTOS_OPC_CLR_FLG,
        `RTOS_OPC_REF_TSKSTAT, `RTOS_OPC_REF_SEMCNT, `RTOS_OPC_REF_FLGPTN, `RTOS_OPC_SLP_TSK,
        `RTOS_OPC_WUP_TSK, `RTOS_OPC_CPU_CTL, `RTOS_OPC_SIG_SEM, 8'h55
    };
    localparam logic [7:0] CTL_IDS [8] = '{8'h00, 8'h04, 8'h08, 8'h10, 8'h11, 8'h04, 8'h08, 8'h07};
    localparam logic [7:0] CFG_IDS [8] = '{8'h00, 8'h20, 8'h21, 8'h22, 8'h23, 8'h01, 8'h20, 8'h00};

    logic                   clk;
    logic                   rst_n_i;
    logic                   stb_i;
    logic                   we_i;
    logic [`RTOS_ADR_W-1:0] adr_i;
    logic [`RTOS_SEL_W-1:0] sel_i;
    logic [`RTOS_DAT_W-1:0] dat_i;
    logic                   ack_o;
    logic [`RTOS_DAT_W-1:0] dat_o;
    logic                   irq_o;

    // reference model
    logic [7:1]  m_rdy;
    logic [2:0]  m_run;
    logic        m_irq_en;
    logic        m_mis_q;
    logic        m_irq_q;
    logic [3:0]  m_sem [1:3];
    logic [15:0] m_flg [1:2];

    int unsigned rnd_state;
    int          err_data;
    int          err_ctl;

    rtos_top dut0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .adr_i   (adr_i),
        .sel_i   (sel_i),
        .dat_i   (dat_i),
        .ack_o   (ack_o),
        .dat_o   (dat_o),
        .irq_o   (irq_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_random();
        rnd_state = rnd_state * 32'd1103515245 + 32'd12345;
        return rnd_state >> 16;
    endfunction

    function automatic logic id_valid(input logic [7:0] id, input int tmax);
        return (id != 8'd0) && (int'(id) <= tmax);
    endfunction

    // lowest-numbered ready task, 0 if none
    function automatic logic [2:0] model_top();
        logic [2:0] top;
        top = 3'd0;
        for (int i = 1; i <= 7; i++) begin
            if (m_rdy[i] && top == 3'd0) begin
                top = 3'(i);
            end
        end
        return top;
    endfunction

    function automatic logic [31:0] expected_read(input logic [7:0] opc, input logic [7:0] id);
        logic [31:0] v;
        v = 32'h0;
        case (opc)
            `RTOS_OPC_SYS_CFG: begin
                if (id == 8'h00) v = `RTOS_CORE_ID;
                if (id == 8'h20) v = 32'd7;
                if (id == 8'h21) v = 32'd3;
                if (id == 8'h22) v = 32'd2;
            end
            `RTOS_OPC_CPU_CTL: begin
                if (id == 8'h00 || id == 8'h08) v = 32'(model_top());
                if (id == 8'h04) v = 32'(m_run);
                if (id == 8'h10) v = 32'(m_irq_en);
                if (id == 8'h11) v = 32'(m_irq_q & m_irq_en);
            end
            `RTOS_OPC_POL_SEM:
                if (id_valid(id, 3)) v = (m_sem[id[1:0]] != 4'd0) ? 32'd1 : 32'd0;
            `RTOS_OPC_REF_TSKSTAT:
                if (id_valid(id, 7)) v = m_rdy[id[2:0]] ? 32'd1 : 32'd4;
            `RTOS_OPC_REF_SEMCNT: if (id_valid(id, 3)) v = 32'(m_sem[id[1:0]]);
            `RTOS_OPC_REF_FLGPTN: if (id_valid(id, 2)) v = 32'(m_flg[id[1:0]]);
            default: ;
        endcase
        return v;
    endfunction

    // one rising edge of the model
    task automatic update_model(input logic stb, input logic we, input logic [15:0] adr,
                                input logic [3:0] sel, input logic [31:0] dat);
        logic [7:0] opc;
        logic [7:0] id;
        logic [2:0] top;
        logic       mis;
        opc = adr[15:8];
        id = adr[7:0];
        top = model_top();
        mis = (top != m_run);
        m_irq_q = mis && m_mis_q;
        m_mis_q = mis;
        if (stb && we && sel == 4'hf) begin
            case (opc)
                `RTOS_OPC_CPU_CTL: begin
                    if (id == 8'h04) m_run = dat[2:0];
                    if (id == 8'h10) m_irq_en = dat[0];
                end
                `RTOS_OPC_WUP_TSK: if (id_valid(id, 7)) m_rdy[id[2:0]] = 1'b1;
                `RTOS_OPC_SLP_TSK: if (id_valid(id, 7)) m_rdy[id[2:0]] = 1'b0;
                `RTOS_OPC_SIG_SEM:
                    if (id_valid(id, 3) && m_sem[id[1:0]] != 4'd15) begin
                        m_sem[id[1:0]] = m_sem[id[1:0]] + 4'd1;
                    end
                `RTOS_OPC_SET_FLG: if (id_valid(id, 2)) m_flg[id[1:0]] |= dat[15:0];
                `RTOS_OPC_CLR_FLG: if (id_valid(id, 2)) m_flg[id[1:0]] &= dat[15:0];
                default: ;
            endcase
        end else if (stb && !we) begin
            if (opc == `RTOS_OPC_CPU_CTL && id == 8'h08) m_run = top;
            if (opc == `RTOS_OPC_POL_SEM && id_valid(id, 3) && m_sem[id[1:0]] != 4'd0) begin
                m_sem[id[1:0]] = m_sem[id[1:0]] - 4'd1;
            end
        end
    endtask

    // starts and ends on a falling edge
    task automatic run_cycle(input logic stb, input logic we, input logic [15:0] adr,
                             input logic [3:0] sel, input logic [31:0] dat);
        logic [31:0] exp_dat;
        stb_i = stb;
        we_i = we;
        adr_i = adr;
        sel_i = sel;
        dat_i = dat;
        #1;
        assert (ack_o === stb_i) else begin
            err_ctl++;
            $display("MISMATCH ack_o exp=%h got=%h", stb_i, ack_o);
        end
        assert (irq_o === (m_irq_q & m_irq_en)) else begin
            err_ctl++;
            $display("MISMATCH irq_o exp=%h got=%h", m_irq_q & m_irq_en, irq_o);
        end
        if (stb && !we) begin
            exp_dat = expected_read(adr[15:8], adr[7:0]);
            assert (dat_o === exp_dat) else begin
                err_data++;
                $display("MISMATCH dat_o adr=%h exp=%h got=%h", adr, exp_dat, dat_o);
            end
        end
        @(posedge clk);
        update_model(stb, we, adr, sel, dat);
        @(negedge clk);
    endtask

    task automatic random_access();
        logic [7:0]  opc;
        logic [7:0]  id;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] dat;
        int unsigned r;
        opc = OPC_TABLE[4'(next_random() % 16)];
        r = next_random();
        if (opc == `RTOS_OPC_CPU_CTL) begin
            id = CTL_IDS[3'(r % 8)];
        end else if (opc == `RTOS_OPC_SYS_CFG) begin
            id = CFG_IDS[3'(r % 8)];
        end else begin
            id = 8'(r % 10);
        end
        r = next_random();
        if (opc inside {`RTOS_OPC_WUP_TSK, `RTOS_OPC_SLP_TSK, `RTOS_OPC_SIG_SEM,
                        `RTOS_OPC_SET_FLG, `RTOS_OPC_CLR_FLG}) begin
            we = (r % 8 != 0);
        end else if (opc == `RTOS_OPC_CPU_CTL) begin
            we = r[0];
        end else begin
            we = (r % 8 == 0);
        end
        r = next_random();
        sel = (r % 4 == 0) ? 4'(r >> 4) : 4'hf;
        dat = {16'(next_random()), 16'(next_random())};
        run_cycle(1'b1, we, {opc, id}, sel, dat);
        if (next_random() % 4 == 0) begin
            run_cycle(1'b0, 1'b0, 16'h0, 4'h0, 32'h0);
        end
    endtask

    // --------------------
    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: stimulus did not complete within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        stb_i = 1'b0;
        we_i = 1'b0;
        adr_i = '0;
        sel_i = '0;
        dat_i = '0;
        rnd_state = 32'd40930;
        err_data = 0;
        err_ctl = 0;
        m_rdy = '1;
        m_run = 3'd0;
        m_irq_en = 1'b0;
        m_mis_q = 1'b0;
        m_irq_q = 1'b0;
        m_sem = '{4'd0, 4'd0, 4'd0};
        m_flg = '{16'h0, 16'h0};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // enable irq, then push semaphore 1 past saturation and drain it past zero
        run_cycle(1'b1, 1'b1, {`RTOS_OPC_CPU_CTL, 8'h10}, 4'hf, 32'h1);
        for (int i = 0; i < 17; i++) begin
            run_cycle(1'b1, 1'b1, {`RTOS_OPC_SIG_SEM, 8'd1}, 4'hf, 32'h0);
            run_cycle(1'b1, 1'b0, {`RTOS_OPC_REF_SEMCNT, 8'd1}, 4'hf, 32'h0);
        end
        for (int i = 0; i < 17; i++) begin
            run_cycle(1'b1, 1'b0, {`RTOS_OPC_POL_SEM, 8'd1}, 4'hf, 32'h0);
        end

        repeat (N_RANDOM) random_access();

        $display("error counts: %0d data mismatches, %0d control mismatches", err_data, err_ctl);
        if (err_data + err_ctl == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+verilog
verilog/rtos_pkg.sv
verilog/rtos_bus_decode.sv
verilog/rtos_task_sched.sv
verilog/rtos_sync_obj.sv
verilog/rtos_read_mux.sv
verilog/rtos_top.sv
verification/rtos_chk.sv
verification/tb_rtos.sv

//--- Makefile
# Verilator build and run for the scheduler register front end

VERILATOR ?= verilator
TOP       ?= tb_rtos
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= ERRORS FOUND

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	@$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
